// File: design/agen_settings.svh
/*
 * global widths for the load/store address stage
 * value width, cache line offset bits, element number bits
 * and the displacement width of the indexed forms
 */
`ifndef AGEN_SETTINGS_SVH
`define AGEN_SETTINGS_SVH

// ============================================================
// datapath widths
// ============================================================

// address and operand width
`define VALUE_W 64

// log2 of the cache line size in bytes
`define LINE_BITS 6

// vector element number width
`define ELEM_BITS 3

// signed displacement of the indexed forms
`define DISP_W 12

`endif

// File: design/isa_pkg.sv
/*
 * instruction side types of the load/store unit
 * memory operation kind, size class and the issue operation
 * struct that is captured by the operation hold register
 */
`include "agen_settings.svh"

package isa_pkg;

	// ============================================================
	// operation kind
	// ============================================================

	// picks the address formula in the generator
	typedef enum logic [2:0]
	{
		MK_LD  = 3'd0,
		MK_ST  = 3'd1,
		MK_LDX = 3'd2,
		MK_STX = 3'd3,
		MK_AMO = 3'd4
	} mem_kind_t;

	// log2 of the byte count
	// 0 byte, 1 wyde, 2 tetra, 3 octa, 4 hexi
	typedef logic [2:0] size_cls_t;

	// ============================================================
	// issue operation
	// ============================================================

	// one memory operation as delivered on the issue port
	typedef struct packed
	{
		mem_kind_t kind;
		size_cls_t size;
		logic vec;
		logic [`ELEM_BITS-1:0] elem;
		logic [`VALUE_W-1:0] base;
		logic [`VALUE_W-1:0] index;
		logic [`VALUE_W-1:0] imm;
		// index shift for the indexed forms
		logic [1:0] scale;
		logic [`DISP_W-1:0] disp;
	} issue_op_t;

endpackage

// File: design/lsu_agen.sv
/*
 * address generator of the load/store unit
 * vector element offset, kind dependent address formula,
 * registered result with next line option and a valid flag
 * that rises two cycles after go and stays until taken
 */
`include "agen_settings.svh"

module lsu_agen
	import isa_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic go,
	// compute the following line aligned address
	input logic next,
	input logic taken,
	input mem_kind_t kind,
	input size_cls_t size,
	input logic vec,
	input logic [`ELEM_BITS-1:0] elem,
	input logic [`VALUE_W-1:0] base,
	input logic [`VALUE_W-1:0] index,
	input logic [`VALUE_W-1:0] imm,
	input logic [1:0] scale,
	input logic [`DISP_W-1:0] disp,
	output addr_t res,
	output logic resv
);

	logic [`VALUE_W-1:0] as;
	logic [`VALUE_W-1:0] bs;
	logic [`VALUE_W-1:0] dx;
	addr_t sum;
	logic resv1;

	// ============================================================
	// operand forming
	// ============================================================

	// vector element offset is the element number times the size
	always_comb
	begin
		if (vec)
			as = base + (`VALUE_W'(elem) << size);
		else
			as = base;
	end

	// scaled index for the indexed forms
	always_comb
		bs = index << scale;

	// sign extended displacement
	always_comb
		dx = {{(`VALUE_W-`DISP_W){disp[`DISP_W-1]}}, disp};

	// address formula by kind
	always_comb
	begin
		case (kind)
		MK_LD, MK_ST:
			sum = as + imm;
		MK_LDX, MK_STX:
			sum = as + bs + dx;
		MK_AMO:
			sum = as + index;
		default:
			sum = as;
		endcase
	end

	// ============================================================
	// result register
	// ============================================================

	// next line is the sum aligned down to a line plus one line
	always_ff @(posedge clk)
	begin
		if (next)
			res <= {sum[`VALUE_W-1:`LINE_BITS] + 1'b1, {`LINE_BITS{1'b0}}};
		else
			res <= sum;
	end

	// sticky valid in two steps
	// first step marks the compute cycle, second the settled result
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resv1 <= 1'b0;
			resv <= 1'b0;
		end
		else if (taken)
		begin
			// the consumer has the address, taken beats a new go
			resv1 <= 1'b0;
			resv <= 1'b0;
		end
		else
		begin
			if (go)
				resv1 <= 1'b1;
			resv <= resv1;
		end
	end

endmodule

// File: design/lsu_agen_top.sv
/*
 * top of the load/store address stage
 * controller, address generator, line counter and the
 * operation and request hold registers
 */
`include "agen_settings.svh"

module lsu_agen_top
	import isa_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	// issue port
	input logic op_req,
	output logic op_ack,
	input mem_kind_t op_kind,
	input size_cls_t op_size,
	input logic op_vec,
	input logic [`ELEM_BITS-1:0] op_elem,
	input logic [`VALUE_W-1:0] op_base,
	input logic [`VALUE_W-1:0] op_index,
	input logic [`VALUE_W-1:0] op_imm,
	input logic [1:0] op_scale,
	input logic [`DISP_W-1:0] op_disp,
	// memory port
	output logic mem_req,
	input logic mem_ack,
	output addr_t mem_addr,
	output size_cls_t mem_size,
	output logic mem_store,
	output logic mem_last
);

	issue_op_t op_d;
	issue_op_t op_q;
	mem_req_t req_d;
	mem_req_t req_q;
	addr_t res;
	logic op_full, req_full, resv, more;
	logic go, next, taken, last;
	logic op_load, op_clear, cnt_start, cnt_step, req_load, req_clear;

	// ============================================================
	// payload wiring
	// ============================================================

	assign op_d = '{kind: op_kind, size: op_size, vec: op_vec, elem: op_elem,
		base: op_base, index: op_index, imm: op_imm, scale: op_scale, disp: op_disp};

	// plain and indexed stores write, atomics go out as loads
	assign req_d = '{addr: res, size: op_q.size,
		store: (op_q.kind == MK_ST) || (op_q.kind == MK_STX), last: last};

	assign mem_addr = req_q.addr;
	assign mem_size = req_q.size;
	assign mem_store = req_q.store;
	assign mem_last = req_q.last;

	// ============================================================
	// instances
	// ============================================================

	lsu_ctrl lsu_ctrl_inst (
		.clk(clk), .rst(rst), .op_req(op_req), .op_ack(op_ack),
		.op_full(op_full), .req_full(req_full), .resv(resv), .more(more),
		.mem_ack(mem_ack), .go(go), .next(next), .taken(taken),
		.op_load(op_load), .op_clear(op_clear), .cnt_start(cnt_start),
		.cnt_step(cnt_step), .req_load(req_load), .req_clear(req_clear),
		.mem_req(mem_req), .last(last)
	);

	lsu_hold #(.payload_t(issue_op_t)) op_hold_inst (
		.clk(clk), .rst(rst), .load(op_load), .clear(op_clear),
		.d(op_d), .q(op_q), .full(op_full)
	);

	lsu_agen lsu_agen_inst (
		.clk(clk), .rst(rst), .go(go), .next(next), .taken(taken),
		.kind(op_q.kind), .size(op_q.size), .vec(op_q.vec), .elem(op_q.elem),
		.base(op_q.base), .index(op_q.index), .imm(op_q.imm),
		.scale(op_q.scale), .disp(op_q.disp), .res(res), .resv(resv)
	);

	lsu_line_cnt lsu_line_cnt_inst (
		.clk(clk), .rst(rst), .start(cnt_start), .step(cnt_step),
		.addr(res), .size(op_q.size), .more(more)
	);

	lsu_hold #(.payload_t(mem_req_t)) req_hold_inst (
		.clk(clk), .rst(rst), .load(req_load), .clear(req_clear),
		.d(req_d), .q(req_q), .full(req_full)
	);

endmodule

// File: design/lsu_ctrl.sv
/*
 * control FSM of the load/store address stage
 * runs the four-phase issue and memory handshakes,
 * starts the generator, loads and steps the line counter
 * and loads and clears both hold registers
 */
module lsu_ctrl
(
	input logic clk,
	input logic rst,
	input logic op_req,
	output logic op_ack,
	input logic op_full,
	input logic req_full,
	input logic resv,
	input logic more,
	input logic mem_ack,
	output logic go,
	output logic next,
	output logic taken,
	output logic op_load,
	output logic op_clear,
	output logic cnt_start,
	output logic cnt_step,
	output logic req_load,
	output logic req_clear,
	output logic mem_req,
	output logic last
);

	typedef enum logic [2:0]
	{
		IDLE,
		CAPTURE,
		CALC,
		ISSUE,
		WAIT_ACK,
		WAIT_DROP,
		WAIT_REQ_LOW
	} state_t;

	state_t state;
	state_t state_nxt;
	// high while the next line access is being formed
	logic second;

	// ============================================================
	// next state and strobes
	// ============================================================

	always_comb
	begin
		state_nxt = state;
		op_load = 1'b0;
		op_clear = 1'b0;
		go = 1'b0;
		taken = 1'b0;
		cnt_start = 1'b0;
		cnt_step = 1'b0;
		req_load = 1'b0;
		req_clear = 1'b0;
		case (state)
		IDLE:
			// new request only once the previous ack is gone
			if (op_req && !op_ack)
			begin
				op_load = 1'b1;
				state_nxt = CAPTURE;
			end
		CAPTURE:
			// operation fields are in the hold, start the generator
			if (op_full)
			begin
				go = 1'b1;
				state_nxt = CALC;
			end
		CALC:
		begin
			// res is settled here, count lines on the first run only
			cnt_start = !second;
			state_nxt = ISSUE;
		end
		ISSUE:
			if (resv)
			begin
				req_load = 1'b1;
				taken = 1'b1;
				state_nxt = WAIT_ACK;
			end
		WAIT_ACK:
			if (mem_ack)
				state_nxt = WAIT_DROP;
		WAIT_DROP:
			// access is complete once the responder drops its ack
			if (!mem_ack)
			begin
				req_clear = 1'b1;
				cnt_step = 1'b1;
				if (more)
					state_nxt = CAPTURE;
				else
				begin
					op_clear = 1'b1;
					state_nxt = WAIT_REQ_LOW;
				end
			end
		WAIT_REQ_LOW:
			// issue handshake must be back to rest before idling
			if (!op_ack)
				state_nxt = IDLE;
		default:
			state_nxt = IDLE;
		endcase
	end

	// ============================================================
	// registers
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// set for the second access, dropped when the operation ends
	always_ff @(posedge clk)
	begin
		if (rst)
			second <= 1'b0;
		else if (state == WAIT_DROP && !mem_ack)
			second <= more;
	end

	// issue ack, up on capture, down once op_req has fallen
	always_ff @(posedge clk)
	begin
		if (rst)
			op_ack <= 1'b0;
		else if (op_load)
			op_ack <= 1'b1;
		else if (op_ack && !op_req)
			op_ack <= 1'b0;
	end

	// memory request is up only while a loaded request waits for ack
	always_comb
		mem_req = (state == WAIT_ACK) && req_full;

	always_comb
		next = second;

	// no further access owed after this one
	always_comb
		last = !more;

endmodule

// File: design/lsu_hold.sv
/*
 * capture register with a full flag
 * generic over its payload type, used for the issue
 * operation and for the outgoing memory request
 */
module lsu_hold #(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic clear,
	input payload_t d,
	output payload_t q,
	output logic full
);

	// payload only changes on a load into an empty slot
	always_ff @(posedge clk)
	begin
		if (load && !full)
			q <= d;
	end

	// full flag, clear has priority
	always_ff @(posedge clk)
	begin
		if (rst || clear)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;
	end

endmodule

// File: design/lsu_line_cnt.sv
/*
 * line access counter of the load/store unit
 * detects a cache line crossing from the address offset
 * and the byte count, then counts the owed accesses down
 */
`include "agen_settings.svh"

module lsu_line_cnt
	import isa_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic step,
	input addr_t addr,
	input size_cls_t size,
	output logic more
);

	line_off_t off;
	logic [`LINE_BITS:0] bytes;
	logic [`LINE_BITS:0] end_pos;
	logic spill;
	logic [1:0] count;

	// ============================================================
	// crossing test
	// ============================================================

	always_comb
		off = addr[`LINE_BITS-1:0];

	// byte count from the size class, 1 to 16
	always_comb
		bytes = (`LINE_BITS+1)'(1) << size;

	// one past the last byte touched, relative to the line start
	always_comb
		end_pos = {1'b0, off} + bytes;

	// spills when the access runs past the line end
	always_comb
		spill = end_pos > (`LINE_BITS+1)'(1 << `LINE_BITS);

	// ============================================================
	// access count
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			count <= 2'd0;
		else if (start)
			count <= spill ? 2'd2 : 2'd1;
		else if (step && count != 2'd0)
			count <= count - 2'd1;
	end

	// another access still owed after the current one
	always_comb
		more = count > 2'd1;

endmodule

// File: design/mem_pkg.sv
/*
 * memory side types of the load/store unit
 * address, line offset and the request struct
 * that is held on the memory port
 */
`include "agen_settings.svh"

package mem_pkg;

	import isa_pkg::*;

	// full effective address
	typedef logic [`VALUE_W-1:0] addr_t;

	// byte position inside one cache line
	typedef logic [`LINE_BITS-1:0] line_off_t;

	// one access as presented to the memory side
	typedef struct packed
	{
		addr_t addr;
		size_cls_t size;
		logic store;
		// set on the final access of an operation
		logic last;
	} mem_req_t;

endpackage

// File: lsu_agen_top.f
+incdir+design
design/isa_pkg.sv
design/mem_pkg.sv
design/lsu_hold.sv
design/lsu_agen.sv
design/lsu_line_cnt.sv
design/lsu_ctrl.sv
design/lsu_agen_top.sv
tb/tb_lsu_agen_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_lsu_agen_top -f lsu_agen_top.f -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"

// File: tb/tb_lsu_agen_top.sv
/*
 * testbench of the load/store address stage
 * clock and reset, xorshift stimulus on the issue port,
 * memory responder with random ack delay, reference address
 * function, access comparison and a cycle limit
 */
`include "agen_settings.svh"

module tb_lsu_agen_top
	import isa_pkg::*;
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// 200 operations at about 40 cycles each
	localparam int OPS_TOTAL = 200;
	localparam int CYCLES_PER_OP = 40;
	localparam int MAX_CYCLES = OPS_TOTAL * CYCLES_PER_OP;

	logic clk;
	logic rst;
	logic op_req;
	logic op_ack;
	mem_kind_t op_kind;
	size_cls_t op_size;
	logic op_vec;
	logic [`ELEM_BITS-1:0] op_elem;
	logic [`VALUE_W-1:0] op_base;
	logic [`VALUE_W-1:0] op_index;
	logic [`VALUE_W-1:0] op_imm;
	logic [1:0] op_scale;
	logic [`DISP_W-1:0] op_disp;
	logic mem_req;
	logic mem_ack;
	addr_t mem_addr;
	size_cls_t mem_size;
	logic mem_store;
	logic mem_last;

	// expected and observed accesses, in order
	mem_req_t exp_q[$];
	mem_req_t obs_q[$];
	logic [63:0] stim_rng = 64'd48;
	logic [63:0] resp_rng;
	logic ack_prev = 1'b0;
	int errors = 0;
	int checks = 0;
	int accesses = 0;
	int ops_sent = 0;
	int ack_rises = 0;
	int cycles = 0;

	lsu_agen_top lsu_agen_top_inst (.*);

	// ============================================================
	// clock, cycle limit and ack counter
	// ============================================================

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// one rise of op_ack per accepted operation
	always @(negedge clk)
	begin
		if (op_ack && !ack_prev)
			ack_rises = ack_rises + 1;
		ack_prev = op_ack;
	end

	// ============================================================
	// random numbers and reference model
	// ============================================================

	function automatic logic [63:0] xorshift(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	function automatic logic [63:0] next_rand();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	// effective address straight from the addressing rules
	function automatic addr_t ref_addr(input issue_op_t op);
		addr_t a;
		a = op.base;
		// vector element sits elem times the byte count above base
		if (op.vec)
			a = a + addr_t'(op.elem) * (addr_t'(1) << op.size);
		case (op.kind)
		MK_LD, MK_ST:
			a = a + op.imm;
		MK_LDX, MK_STX:
			a = a + op.index * (addr_t'(1) << op.scale) + addr_t'($signed(op.disp));
		default:
			a = a + op.index;
		endcase
		return a;
	endfunction

	// queue the access list of one operation
	task automatic expect_op(input issue_op_t op);
		mem_req_t acc;
		addr_t a;
		a = ref_addr(op);
		acc.addr = a;
		acc.size = op.size;
		acc.store = (op.kind == MK_ST) || (op.kind == MK_STX);
		// past the line end so a second access follows at the next line start
		if (int'(a[`LINE_BITS-1:0]) + (1 << op.size) > (1 << `LINE_BITS))
		begin
			acc.last = 1'b0;
			exp_q.push_back(acc);
			acc.addr = (a | addr_t'((1 << `LINE_BITS) - 1)) + addr_t'(1);
		end
		acc.last = 1'b1;
		exp_q.push_back(acc);
	endtask

	// ============================================================
	// memory responder and comparison
	// ============================================================

	task automatic check_held(input mem_req_t seen);
		assert (mem_req && mem_addr == seen.addr && mem_size == seen.size
			&& mem_store == seen.store && mem_last == seen.last)
		else
		begin
			$display("request at %h changed or dropped before its ack at %0t", seen.addr, $time);
			errors++;
		end
	endtask

	// log the access and ack after 0 to 7 cycles, then release once mem_req drops
	task automatic serve_access();
		mem_req_t seen;
		int delay;
		seen = '{addr: mem_addr, size: mem_size, store: mem_store, last: mem_last};
		obs_q.push_back(seen);
		accesses++;
		resp_rng = xorshift(resp_rng);
		delay = int'(resp_rng[2:0]);
		repeat (delay)
		begin
			@(negedge clk);
			check_held(seen);
		end
		mem_ack = 1'b1;
		@(negedge clk);
		while (mem_req)
		begin
			check_held(seen);
			@(negedge clk);
		end
		mem_ack = 1'b0;
	endtask

	initial
	begin
		mem_ack = 1'b0;
		// own stream so the ack delays do not shift the stimulus
		resp_rng = xorshift(xorshift(64'd48));
		forever
		begin
			@(negedge clk);
			if (mem_req && !rst)
				serve_access();
		end
	end

	always @(posedge clk)
	begin : compare
		mem_req_t got;
		mem_req_t want;
		while (obs_q.size() > 0)
		begin
			got = obs_q.pop_front();
			if (exp_q.size() == 0)
			begin
				$display("extra access to %h at %0t with nothing expected", got.addr, $time);
				errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				checks++;
				assert (got.addr == want.addr)
				else
				begin
					$display("ERR t=%0t mem_addr expected %h got %h", $time, want.addr, got.addr);
					errors++;
				end
				assert (got.size == want.size)
				else
				begin
					$display("ERR t=%0t mem_size expected %0d got %0d", $time, want.size, got.size);
					errors++;
				end
				assert (got.store == want.store)
				else
				begin
					$display("ERR t=%0t mem_store expected %b got %b", $time, want.store, got.store);
					errors++;
				end
				assert (got.last == want.last)
				else
				begin
					$display("ERR t=%0t mem_last expected %b got %b", $time, want.last, got.last);
					errors++;
				end
			end
		end
	end

	// ============================================================
	// stimulus helpers
	// ============================================================

	function automatic issue_op_t random_op();
		issue_op_t op;
		logic [63:0] r;
		r = next_rand();
		op.kind = mem_kind_t'(3'(r % 64'd5));
		op.size = size_cls_t'((r >> 8) % 64'd5);
		op.vec = r[16];
		op.elem = r[19:17];
		op.scale = r[21:20];
		op.disp = r[33:22];
		op.base = next_rand();
		op.index = next_rand();
		op.imm = next_rand();
		return op;
	endfunction

	// plain load or store whose bytes run over the line end
	function automatic issue_op_t crossing_op(input int i);
		issue_op_t op;
		logic [63:0] r;
		int bytes;
		int off;
		op = random_op();
		op.kind = i[0] ? MK_ST : MK_LD;
		op.vec = 1'b0;
		op.size = size_cls_t'(1 + i % 4);
		bytes = 1 << op.size;
		off = 63 - int'(next_rand() % 64'(bytes - 1));
		r = next_rand();
		// imm is a whole number of lines so base alone sets the offset
		op.imm = {r[63:6], 6'd0};
		op.base = {op.base[63:6], 6'(off)};
		return op;
	endfunction

	// full four-phase issue handshake for one operation
	task automatic run_op(input issue_op_t op, input int gap);
		repeat (gap) @(negedge clk);
		expect_op(op);
		op_kind = op.kind;
		op_size = op.size;
		op_vec = op.vec;
		op_elem = op.elem;
		op_base = op.base;
		op_index = op.index;
		op_imm = op.imm;
		op_scale = op.scale;
		op_disp = op.disp;
		op_req = 1'b1;
		ops_sent++;
		@(negedge clk);
		while (!op_ack) @(negedge clk);
		op_req = 1'b0;
		@(negedge clk);
		while (op_ack) @(negedge clk);
	endtask

	// let the last accesses drain, then check nothing went missing
	task automatic end_test(input string name, input int n_ops, input int errs_start);
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || mem_req || mem_ack) && waited < 200)
		begin
			@(negedge clk);
			waited++;
		end
		repeat (4) @(negedge clk);
		assert (exp_q.size() == 0)
		else
		begin
			$display("%0d expected accesses never appeared by %0t", exp_q.size(), $time);
			errors++;
			exp_q.delete();
		end
		assert (ack_rises == ops_sent)
		else
		begin
			$display("op_ack rose %0d times for %0d operations", ack_rises, ops_sent);
			errors++;
		end
		$display("test %-16s %3d ops, %0d errors", name, n_ops, errors - errs_start);
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial
	begin
		issue_op_t op;
		int errs_start;
		rst = 1'b1;
		op_req = 1'b0;
		op_kind = MK_LD;
		op_size = '0;
		op_vec = 1'b0;
		op_elem = '0;
		op_base = '0;
		op_index = '0;
		op_imm = '0;
		op_scale = '0;
		op_disp = '0;
		// two rising edges in reset, release on the falling edge after them
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// quiet ports after reset and no access without an operation
		errs_start = errors;
		repeat (10)
		begin
			@(negedge clk);
			assert (!op_ack && !mem_req)
			else
			begin
				$display("op_ack or mem_req high after reset at %0t", $time);
				errors++;
			end
		end
		end_test("reset", 0, errs_start);

		// loads and stores, both kinds at each size
		errs_start = errors;
		for (int i = 0; i < 40; i++)
		begin
			op = random_op();
			op.kind = i[0] ? MK_ST : MK_LD;
			op.size = size_cls_t'((i / 2) % 5);
			op.vec = 1'b0;
			run_op(op, 0);
		end
		end_test("load_store", 40, errs_start);

		// indexed and atomic with every other displacement negative
		errs_start = errors;
		for (int i = 0; i < 45; i++)
		begin
			op = random_op();
			case (i % 3)
			0: op.kind = MK_LDX;
			1: op.kind = MK_STX;
			default: op.kind = MK_AMO;
			endcase
			op.vec = 1'b0;
			op.disp[`DISP_W-1] = i[0];
			run_op(op, 0);
		end
		end_test("indexed_atomic", 45, errs_start);

		errs_start = errors;
		for (int i = 0; i < 30; i++)
		begin
			op = random_op();
			op.vec = 1'b1;
			op.size = size_cls_t'(i % 5);
			run_op(op, 0);
		end
		end_test("vector", 30, errs_start);

		errs_start = errors;
		for (int i = 0; i < 25; i++)
			run_op(crossing_op(i), 0);
		end_test("line_cross", 25, errs_start);

		// anything goes with random gaps between requests
		errs_start = errors;
		for (int i = 0; i < 60; i++)
			run_op(random_op(), int'(next_rand() % 64'd4));
		end_test("random", 60, errs_start);

		$display("summary %0d ops, %0d accesses, %0d checks, %0d errors",
			ops_sent, accesses, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
